// ==== clock_pkg.sv ====
/*
 * shared types and constants for the six-digit digital clock
 * referenced by scoped name from every design file
 */
package clock_pkg;

	// ------------------------------------------------------------
	// time of day
	// ------------------------------------------------------------

	// width of one hh, mm or ss field
	localparam int DIGIT_PAIR_W = 6;

	// last legal value of each field
	localparam logic [DIGIT_PAIR_W-1:0] SEC_MAX = 6'd59;
	localparam logic [DIGIT_PAIR_W-1:0] MIN_MAX = 6'd59;
	localparam logic [DIGIT_PAIR_W-1:0] HOU_MAX = 6'd23;

	// hours in the top bits, 18 bits total
	typedef struct packed {
		logic [DIGIT_PAIR_W-1:0] hou;
		logic [DIGIT_PAIR_W-1:0] min;
		logic [DIGIT_PAIR_W-1:0] sec;
	} hms_t;

	// ------------------------------------------------------------
	// user state
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_e;

	// bit positions inside the button and press vectors
	typedef enum logic [1:0] {
		BTN_MODE  = 2'd0,
		BTN_POS   = 2'd1,
		BTN_INC   = 2'd2,
		BTN_ALARM = 2'd3
	} btn_idx;

	// display geometry
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

endpackage

// ==== cnt_ctrl_if.sv ====
/*
 * strobe bundle from the controller to one hh:mm:ss counter
 * every signal is a single-cycle pulse, no acknowledge
 */
`timescale 1ns/1ps

interface cnt_ctrl_if;

	// one-second advance with carry
	logic tick;
	// single-field steps, no carry
	logic inc_sec;
	logic inc_min;
	logic inc_hou;

	// controller side
	modport ctrl (
		output tick, inc_sec, inc_min, inc_hou
	);

	// counter side
	modport cnt (
		input tick, inc_sec, inc_min, inc_hou
	);

endinterface

// ==== tick_gen.sv ====
/*
 * clock enable generator: one-cycle seconds tick and display scan tick
 * each tick repeats every SEC_DIV or SCAN_DIV clk cycles
 */
`timescale 1ns/1ps

module tick_gen #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick
);

	localparam int MAX_DIV = (SEC_DIV > SCAN_DIV) ? SEC_DIV : SCAN_DIV;
	// enough bits for the larger terminal count
	localparam int DIV_W   = (MAX_DIV > 1) ? $clog2(MAX_DIV) : 1;

	// [0] seconds, [1] scan
	logic [1:0] tick;

	// same down-counter for both divisors
	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int DIV = (i == 0) ? SEC_DIV : SCAN_DIV;

		logic [DIV_W-1:0] cnt;

		// reload on terminal count, first tick DIV cycles out of reset
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt <= DIV_W'(DIV - 1);
			end else if (cnt == '0) begin
				cnt <= DIV_W'(DIV - 1);
			end else begin
				cnt <= cnt - 1'b1;
			end
		end

		assign tick[i] = (cnt == '0);
	end

	assign o_sec_tick  = tick[0];
	assign o_scan_tick = tick[1];

endmodule

// ==== button_sync.sv ====
/*
 * push-button sampler: slow sampling on the scan tick filters bounce
 * emits a one-cycle pulse per new press, one bit per button
 */
`timescale 1ns/1ps

module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] i_btn,
	input  logic       i_sample,
	output logic [3:0] o_press
);

	// newest sample and the one before it
	logic [3:0] smp;
	logic [3:0] smp_dly;
	// marks the cycle right after a sample
	logic       sampled;

	// ------------------------------------------------------------
	// two-stage history, enabled by the scan tick
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp     <= '0;
			smp_dly <= '0;
		end else if (i_sample) begin
			smp     <= i_btn;
			smp_dly <= smp;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sampled <= 1'b0;
		end else begin
			sampled <= i_sample;
		end
	end

	// ------------------------------------------------------------
	// rising edge in the sampled history
	// ------------------------------------------------------------
	// only valid for one cycle after the history moved,
	// otherwise a held button would pulse every clk
	assign o_press = {4{sampled}} & smp & ~smp_dly;

endmodule

// ==== hms_counter.sv ====
/*
 * hh:mm:ss counter with 24-hour wrap
 * tick strobe counts seconds with carry, inc strobes step one field
 */
`timescale 1ns/1ps

module hms_counter (
	input  logic            clk,
	input  logic            rst_n,
	cnt_ctrl_if.cnt         bus,
	output clock_pkg::hms_t o_time
);

	// next value of one field, back to zero past its max
	function automatic logic [clock_pkg::DIGIT_PAIR_W-1:0] wrap_inc(
		input logic [clock_pkg::DIGIT_PAIR_W-1:0] value,
		input logic [clock_pkg::DIGIT_PAIR_W-1:0] max
	);
		return (value == max) ? '0 : value + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (bus.tick) begin
			// ripple carry sec -> min -> hou
			o_time.sec <= wrap_inc(o_time.sec, clock_pkg::SEC_MAX);
			if (o_time.sec == clock_pkg::SEC_MAX) begin
				o_time.min <= wrap_inc(o_time.min, clock_pkg::MIN_MAX);
				if (o_time.min == clock_pkg::MIN_MAX) begin
					o_time.hou <= wrap_inc(o_time.hou, clock_pkg::HOU_MAX);
				end
			end
		end else begin
			// manual setting, fields independent
			if (bus.inc_sec) begin
				o_time.sec <= wrap_inc(o_time.sec, clock_pkg::SEC_MAX);
			end
			if (bus.inc_min) begin
				o_time.min <= wrap_inc(o_time.min, clock_pkg::MIN_MAX);
			end
			if (bus.inc_hou) begin
				o_time.hou <= wrap_inc(o_time.hou, clock_pkg::HOU_MAX);
			end
		end
	end

endmodule

// ==== clock_ctrl.sv ====
/*
 * user control: mode, field position and alarm enable from button presses
 * routes tick and increment strobes to the time and alarm counters
 */
`timescale 1ns/1ps

module clock_ctrl (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [3:0]                       i_press,
	input  logic                             i_sec_tick,
	input  clock_pkg::hms_t                  i_time,
	input  clock_pkg::hms_t                  i_alarm_time,
	cnt_ctrl_if.ctrl                         time_bus,
	cnt_ctrl_if.ctrl                         alarm_bus,
	output logic                             o_show_alarm,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_dp_mask,
	output logic                             o_alarm
);

	clock_pkg::mode_e mode;
	clock_pkg::pos_e  pos;
	logic             alarm_en;

	logic             in_setup;
	logic             in_alarm;
	// increment press steered to a field, {hou, min, sec}
	logic [2:0]       inc_field;

	// ------------------------------------------------------------
	// mode, position and alarm enable
	// ------------------------------------------------------------
	// clock -> setup -> alarm -> clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode <= clock_pkg::MODE_CLOCK;
		end else if (i_press[clock_pkg::BTN_MODE]) begin
			case (mode)
				clock_pkg::MODE_CLOCK: mode <= clock_pkg::MODE_SETUP;
				clock_pkg::MODE_SETUP: mode <= clock_pkg::MODE_ALARM;
				default:               mode <= clock_pkg::MODE_CLOCK;
			endcase
		end
	end

	// sec -> min -> hou -> sec
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= clock_pkg::POS_SEC;
		end else if (i_press[clock_pkg::BTN_POS]) begin
			case (pos)
				clock_pkg::POS_SEC: pos <= clock_pkg::POS_MIN;
				clock_pkg::POS_MIN: pos <= clock_pkg::POS_HOU;
				default:            pos <= clock_pkg::POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_en <= 1'b0;
		end else if (i_press[clock_pkg::BTN_ALARM]) begin
			alarm_en <= ~alarm_en;
		end
	end

	// ------------------------------------------------------------
	// strobe routing
	// ------------------------------------------------------------
	assign in_setup = (mode == clock_pkg::MODE_SETUP);
	assign in_alarm = (mode == clock_pkg::MODE_ALARM);

	assign inc_field[0] = i_press[clock_pkg::BTN_INC] & (pos == clock_pkg::POS_SEC);
	assign inc_field[1] = i_press[clock_pkg::BTN_INC] & (pos == clock_pkg::POS_MIN);
	assign inc_field[2] = i_press[clock_pkg::BTN_INC] & (pos == clock_pkg::POS_HOU);

	// time keeps running while the alarm is edited, frozen in setup
	assign time_bus.tick    = i_sec_tick & ~in_setup;
	assign time_bus.inc_sec = inc_field[0] & in_setup;
	assign time_bus.inc_min = inc_field[1] & in_setup;
	assign time_bus.inc_hou = inc_field[2] & in_setup;

	// alarm time only moves by hand
	assign alarm_bus.tick    = 1'b0;
	assign alarm_bus.inc_sec = inc_field[0] & in_alarm;
	assign alarm_bus.inc_min = inc_field[1] & in_alarm;
	assign alarm_bus.inc_hou = inc_field[2] & in_alarm;

	// ------------------------------------------------------------
	// display hints
	// ------------------------------------------------------------
	assign o_show_alarm = in_alarm;

	// both digits of the field being edited get the dot
	always_comb begin
		o_dp_mask = '0;
		if (in_setup || in_alarm) begin
			case (pos)
				clock_pkg::POS_SEC: o_dp_mask[1:0] = 2'b11;
				clock_pkg::POS_MIN: o_dp_mask[3:2] = 2'b11;
				clock_pkg::POS_HOU: o_dp_mask[5:4] = 2'b11;
				default:            o_dp_mask      = '0;
			endcase
		end
	end

	// alarm latch: set on match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= alarm_en & (o_alarm | (i_time == i_alarm_time));
		end
	end

endmodule

// ==== seg_display.sv ====
/*
 * six-digit multiplexed seven-segment driver
 * one digit per scan tick, segments active high, enables active low
 */
`timescale 1ns/1ps

module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_scan,
	input  clock_pkg::hms_t                  i_time,
	input  clock_pkg::hms_t                  i_alarm_time,
	input  logic                             i_show_alarm,
	input  logic [clock_pkg::NUM_DIGITS-1:0] i_dp_mask,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W = $clog2(clock_pkg::NUM_DIGITS);

	logic [IDX_W-1:0]                  digit_idx;
	clock_pkg::hms_t                   shown;
	logic [clock_pkg::DIGIT_PAIR_W-1:0] field;
	logic [3:0]                        bcd;

	// decimal digit to {a,b,c,d,e,f,g}
	function automatic logic [clock_pkg::SEG_W-1:0] seg_decode(input logic [3:0] num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_1011;
			default: return 7'b000_0000;
		endcase
	endfunction

	// ------------------------------------------------------------
	// scan position
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_idx <= '0;
		end else if (i_scan) begin
			if (digit_idx == IDX_W'(clock_pkg::NUM_DIGITS - 1)) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// digit value
	// ------------------------------------------------------------
	assign shown = i_show_alarm ? i_alarm_time : i_time;

	// pairs of digits share a field, odd index is the tens digit
	always_comb begin
		case (digit_idx[IDX_W-1:1])
			2'd0:    field = shown.sec;
			2'd1:    field = shown.min;
			default: field = shown.hou;
		endcase
	end

	assign bcd = digit_idx[0] ? 4'(field / 10) : 4'(field % 10);

	// ------------------------------------------------------------
	// outputs follow the index directly
	// ------------------------------------------------------------
	assign o_seg    = seg_decode(bcd);
	assign o_seg_dp = i_dp_mask[digit_idx];

	// one-hot low common node
	always_comb begin
		o_seg_enb            = '1;
		o_seg_enb[digit_idx] = 1'b0;
	end

endmodule

// ==== digital_clock.sv ====
/*
 * 24-hour digital clock with alarm, four buttons and six-digit display
 * SEC_DIV and SCAN_DIV set the tick rates from clk
 */
`timescale 1ns/1ps

module digital_clock #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_btn_mode,
	input  logic                             i_btn_pos,
	input  logic                             i_btn_inc,
	input  logic                             i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                             o_alarm
);

	logic                             sec_tick;
	logic                             scan_tick;
	logic [3:0]                       btn;
	logic [3:0]                       press;
	clock_pkg::hms_t                  cur_time;
	clock_pkg::hms_t                  alarm_time;
	logic                             show_alarm;
	logic [clock_pkg::NUM_DIGITS-1:0] dp_mask;

	// strobes to each counter
	cnt_ctrl_if time_bus ();
	cnt_ctrl_if alarm_bus ();

	// buttons packed by their package index
	assign btn[clock_pkg::BTN_MODE]  = i_btn_mode;
	assign btn[clock_pkg::BTN_POS]   = i_btn_pos;
	assign btn[clock_pkg::BTN_INC]   = i_btn_inc;
	assign btn[clock_pkg::BTN_ALARM] = i_btn_alarm;

	tick_gen #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV)
	) u_tick_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_scan_tick (scan_tick)
	);

	// buttons sampled at the scan rate
	button_sync u_button_sync (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_btn    (btn),
		.i_sample (scan_tick),
		.o_press  (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_press      (press),
		.i_sec_tick   (sec_tick),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.time_bus     (time_bus.ctrl),
		.alarm_bus    (alarm_bus.ctrl),
		.o_show_alarm (show_alarm),
		.o_dp_mask    (dp_mask),
		.o_alarm      (o_alarm)
	);

	hms_counter u_time_cnt (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (time_bus.cnt),
		.o_time (cur_time)
	);

	hms_counter u_alarm_cnt (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (alarm_bus.cnt),
		.o_time (alarm_time)
	);

	seg_display u_seg_display (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan       (scan_tick),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.i_show_alarm (show_alarm),
		.i_dp_mask    (dp_mask),
		.o_seg        (o_seg),
		.o_seg_dp     (o_seg_dp),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

// ==== tb_digital_clock.sv ====
/*
 * testbench for the digital clock
 * drives the buttons, decodes the scanned display back into hh:mm:ss
 * and checks it against a reference time
 */
`timescale 1ns/1ps

module tb_digital_clock;

	localparam int  CLK_PERIOD   = 20;
	localparam int  SEC_DIV      = 40;
	localparam int  SCAN_DIV     = 2;
	localparam int  RESET_CYCLES = 10;
	localparam int  DAY_SECS     = 86400;
	localparam time SEC_NS       = SEC_DIV * CLK_PERIOD;
	// worst case press is 8 + 3 hold and 8 release scan periods
	localparam int  PRESS_CYCLES = 19 * SCAN_DIV;
	localparam int  MAX_PRESSES  = 340;
	localparam int  TEST_SECS    = 160;
	localparam int  WATCHDOG_CYCLES = MAX_PRESSES * PRESS_CYCLES + TEST_SECS * SEC_DIV + 2000;

	logic                             clk;
	logic                             rst_n;
	logic [3:0]                       btn;
	logic [clock_pkg::SEG_W-1:0]      seg;
	logic                             seg_dp;
	logic [clock_pkg::NUM_DIGITS-1:0] seg_enb;
	logic                             alarm;

	// last steady display reading
	int                               shown_secs;
	logic [clock_pkg::NUM_DIGITS-1:0] shown_dp;
	logic                             alarm_at_start;
	time                              t_rst;

	digital_clock #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[clock_pkg::BTN_MODE]),
		.i_btn_pos   (btn[clock_pkg::BTN_POS]),
		.i_btn_inc   (btn[clock_pkg::BTN_INC]),
		.i_btn_alarm (btn[clock_pkg::BTN_ALARM]),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------
	task automatic fail_run(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string what);
		fail_run($sformatf("Mismatch at %0t: %s", $time, what));
	endtask

	task automatic run_error(input string what);
		fail_run(what);
	endtask

	// ------------------------------------------------------------
	// reference model helpers
	// ------------------------------------------------------------
	function automatic string hms_text(input int t);
		return $sformatf("%02d:%02d:%02d", t / 3600, (t / 60) % 60, t % 60);
	endfunction

	// one field stepped n times and wrapped without carry
	function automatic int step_field(input int t, input int field, input int n);
		int h;
		int m;
		int s;
		h = t / 3600;
		m = (t / 60) % 60;
		s = t % 60;
		case (field)
			0:       s = (s + n) % 60;
			1:       m = (m + n) % 60;
			default: h = (h + n) % 24;
		endcase
		return h * 3600 + m * 60 + s;
	endfunction

	// dots on both digits of the edited field
	function automatic logic [5:0] field_mask(input int pos);
		return 6'(3 << (2 * pos));
	endfunction

	// standard a..g patterns back to a digit or 15 for junk
	function automatic logic [3:0] seg_to_digit(input logic [6:0] pattern);
		case (pattern)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_1011: return 4'd9;
			default:     return 4'd15;
		endcase
	endfunction

	// active-low one-hot enable to a digit index or 7 if not one-hot
	function automatic logic [2:0] enabled_digit(input logic [5:0] enb);
		case (enb)
			6'b111110: return 3'd0;
			6'b111101: return 3'd1;
			6'b111011: return 3'd2;
			6'b110111: return 3'd3;
			6'b101111: return 3'd4;
			6'b011111: return 3'd5;
			default:   return 3'd7;
		endcase
	endfunction

	// ------------------------------------------------------------
	// stimulus and display capture
	// ------------------------------------------------------------
	task automatic press_button(input clock_pkg::btn_idx which);
		int extra;
		extra = $urandom_range(3, 0);
		@(negedge clk);
		btn[which] = 1'b1;
		repeat ((8 + extra) * SCAN_DIV) @(negedge clk);
		btn[which] = 1'b0;
		repeat (8 * SCAN_DIV) @(negedge clk);
	endtask

	// one full scan round sampled mid-cycle
	task automatic sample_round(output logic [5:0][3:0] digs, output logic [5:0] dps);
		logic [5:0] seen;
		logic [2:0] idx;
		seen = '0;
		digs = '0;
		dps  = '0;
		repeat (clock_pkg::NUM_DIGITS * SCAN_DIV) begin
			@(negedge clk);
			idx = enabled_digit(seg_enb);
			assert (idx != 3'd7)
				else value_error($sformatf("enables %b not one low", seg_enb));
			digs[idx] = seg_to_digit(seg);
			dps[idx]  = seg_dp;
			seen[idx] = 1'b1;
		end
		assert (seen == 6'b111111)
			else run_error("a scan round skipped one of the six digits");
	endtask

	// repeat rounds until two agree and then decode
	task automatic read_display();
		logic [5:0][3:0] prev_digs;
		logic [5:0][3:0] digs;
		logic [5:0]      prev_dps;
		logic [5:0]      dps;
		int              tries;
		alarm_at_start = alarm;
		tries = 0;
		sample_round(prev_digs, prev_dps);
		sample_round(digs, dps);
		while ((digs != prev_digs || dps != prev_dps) && tries < 6) begin
			prev_digs = digs;
			prev_dps  = dps;
			sample_round(digs, dps);
			tries++;
		end
		if (digs != prev_digs || dps != prev_dps) begin
			run_error("the display never held still for two scan rounds");
		end
		assert (digs[0] <= 4'd9 && digs[1] <= 4'd9 && digs[2] <= 4'd9 &&
				digs[3] <= 4'd9 && digs[4] <= 4'd9 && digs[5] <= 4'd9)
			else value_error($sformatf("undecodable digits %h", digs));
		shown_secs = (int'(digs[5]) * 10 + int'(digs[4])) * 3600 +
				(int'(digs[3]) * 10 + int'(digs[2])) * 60 +
				int'(digs[1]) * 10 + int'(digs[0]);
		shown_dp = dps;
	endtask

	// running time must approach target with the alarm low until it gets there
	task automatic wait_for_time(input int target, input int behind, input int max_reads);
		int reads;
		int gap;
		reads = 0;
		read_display();
		while (shown_secs != target) begin
			gap = (target - shown_secs + DAY_SECS) % DAY_SECS;
			assert (gap <= behind && alarm_at_start == 1'b0)
				else value_error($sformatf("shown %s waiting for %s, alarm %b",
					hms_text(shown_secs), hms_text(target), alarm_at_start));
			reads++;
			if (reads > max_reads) begin
				run_error($sformatf("the time never reached %s", hms_text(target)));
			end
			read_display();
		end
	endtask

	// step one field to a target value and update the model time
	task automatic set_field(input int field, input int target, inout int t);
		int modulo;
		int cur;
		int n;
		modulo = (field == 2) ? 24 : 60;
		cur = (field == 0) ? t % 60 : (field == 1) ? (t / 60) % 60 : t / 3600;
		n = (target - cur + modulo) % modulo;
		repeat (n) press_button(clock_pkg::BTN_INC);
		t = step_field(t, field, n);
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		int  n;
		int  exp_secs;
		int  model;
		int  t0_secs;
		int  alarm_secs;
		time t0;

		void'($urandom(32'hc059));
		rst_n = 1'b0;
		btn   = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		assert (seg_enb == 6'b111110 && alarm == 1'b0)
			else value_error($sformatf("in reset enb %b alarm %b", seg_enb, alarm));
		rst_n = 1'b1;
		t_rst = $time;

		// reset state
		read_display();
		assert (shown_secs == 0 && shown_dp == 6'b000000 && alarm == 1'b0)
			else value_error($sformatf("after reset %s dp %b", hms_text(shown_secs), shown_dp));

		// free running with one second of slack
		n = $urandom_range(10, 3);
		repeat (n * SEC_DIV) @(negedge clk);
		read_display();
		exp_secs = int'(($time - t_rst) / SEC_NS);
		assert (shown_secs >= exp_secs - 1 && shown_secs <= exp_secs + 1)
			else value_error($sformatf("shown %s, expected about %s",
				hms_text(shown_secs), hms_text(exp_secs)));

		// setup mode freezes the time
		press_button(clock_pkg::BTN_MODE);
		read_display();
		model = shown_secs;
		repeat (3 * SEC_DIV) @(negedge clk);
		read_display();
		assert (shown_secs == model)
			else value_error($sformatf("setup time moved to %s", hms_text(shown_secs)));

		// each field steps alone in position order sec, min, hou
		for (int f = 0; f < 3; f++) begin
			if (f > 0) begin
				press_button(clock_pkg::BTN_POS);
			end
			// enough presses to run the field past its last value
			n = (f == 2) ? 24 - model / 3600 :
				(f == 1) ? 60 - (model / 60) % 60 : 60 - model % 60;
			n = n + $urandom_range(8, 1);
			repeat (n) press_button(clock_pkg::BTN_INC);
			model = step_field(model, f, n);
			read_display();
			assert (shown_secs == model && shown_dp == field_mask(f))
				else value_error($sformatf("field %0d: shown %s dp %b, expected %s dp %b", f,
					hms_text(shown_secs), shown_dp, hms_text(model), field_mask(f)));
		end

		// carry through midnight from the hours position
		set_field(2, 23, model);
		press_button(clock_pkg::BTN_POS);
		set_field(0, 58, model);
		press_button(clock_pkg::BTN_POS);
		set_field(1, 59, model);
		read_display();
		assert (shown_secs == DAY_SECS - 2 && shown_dp == field_mask(1))
			else value_error($sformatf("set time shows %s", hms_text(shown_secs)));
		press_button(clock_pkg::BTN_MODE);
		press_button(clock_pkg::BTN_MODE);
		// time runs through the alarm pass and rolls over to 00:00:01
		wait_for_time(1, 3, 8);

		// alarm editing while the time keeps running underneath
		read_display();
		t0_secs = shown_secs;
		t0 = $time;
		press_button(clock_pkg::BTN_MODE);
		press_button(clock_pkg::BTN_MODE);
		read_display();
		assert (shown_secs == 0 && shown_dp == field_mask(1))
			else value_error($sformatf("alarm shows %s dp %b", hms_text(shown_secs), shown_dp));
		n = $urandom_range(2, 1);
		repeat (n) press_button(clock_pkg::BTN_INC);
		alarm_secs = n * 60;
		press_button(clock_pkg::BTN_POS);
		press_button(clock_pkg::BTN_POS);
		n = $urandom_range(6, 3);
		repeat (n) press_button(clock_pkg::BTN_INC);
		alarm_secs = alarm_secs + n;
		read_display();
		assert (shown_secs == alarm_secs && shown_dp == field_mask(0))
			else value_error($sformatf("alarm shows %s, expected %s",
				hms_text(shown_secs), hms_text(alarm_secs)));

		// back to clock after a setup pass that froze it for about a second
		press_button(clock_pkg::BTN_MODE);
		read_display();
		exp_secs = t0_secs + int'(($time - t0) / SEC_NS);
		assert (shown_secs >= exp_secs - 3 && shown_secs <= exp_secs + 1 &&
				shown_dp == 6'b000000 && alarm == 1'b0)
			else value_error($sformatf("time %s after alarm edit, expected about %s",
				hms_text(shown_secs), hms_text(exp_secs)));

		// armed alarm latches at the match and holds past it
		press_button(clock_pkg::BTN_ALARM);
		wait_for_time(alarm_secs, 200, 400);
		repeat (2) @(negedge clk);
		assert (alarm == 1'b1)
			else value_error($sformatf("alarm low at %s", hms_text(shown_secs)));
		repeat (2 * SEC_DIV) @(negedge clk);
		read_display();
		assert (shown_secs > alarm_secs && alarm == 1'b1)
			else value_error($sformatf("alarm %b at %s", alarm, hms_text(shown_secs)));
		press_button(clock_pkg::BTN_ALARM);
		assert (alarm == 1'b0)
			else value_error("alarm still high after disable");

		$display("TEST OK");
		$finish;
	end

	// run limit from the press count and the waits above
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		run_error("watchdog expired before the tests finished");
	end

endmodule

// ==== digital_clock.f ====
clock_pkg.sv
cnt_ctrl_if.sv
tick_gen.sv
button_sync.sv
hms_counter.sv
clock_ctrl.sv
seg_display.sv
digital_clock.sv
tb_digital_clock.sv

// ==== Makefile ====
# Verilator flow for the digital clock

VERILATOR  ?= verilator
TOP        := tb_digital_clock
RTL_TOP    := digital_clock
FILELIST   := digital_clock.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
